// File: hw/act_pkg.sv
// Activation queue formats
`default_nettype none

package act_pkg;

	// Signed activation value from the input stream
	localparam int ACT_WIDTH = 8;

	// Column index carried next to each nonzero activation
	// 4 bits, so at most 16 columns
	localparam int INDEX_WIDTH = 4;

	// One queue word, activation above index
	localparam int QENTRY_WIDTH = ACT_WIDTH + INDEX_WIDTH;

endpackage : act_pkg

`default_nettype wire

// File: hw/pe_pkg.sv
// Processing element number formats
`default_nettype none

package pe_pkg;

	// Signed weight held in each PE
	localparam int WEIGHT_WIDTH = 8;

	// Signed row accumulator
	// Wraps modulo 2**24, no saturation
	localparam int ACC_WIDTH = 24;

endpackage : pe_pkg

`default_nettype wire

// File: hw/ccu_broadcast.sv
// Zero-skipping activation broadcaster
`timescale 1ns/10ps
`default_nettype none

module ccu_broadcast import act_pkg::*; #(
	parameter int NUM_PE = 4
) (
	input  wire logic                          clk,
	input  wire logic                          rstn,
	input  wire logic                          clear_i,

	// Incoming activation stream
	input  wire logic                          act_valid_i,
	input  wire logic signed [ACT_WIDTH-1:0]   act_i,
	input  wire logic                          act_last_i,
	output      logic                          act_ready_o,

	// Broadcast to every PE queue
	input  wire logic [NUM_PE-1:0]             q_full_i,
	output      logic                          q_we_o,
	output      logic signed [ACT_WIDTH-1:0]   q_act_o,
	output      logic [INDEX_WIDTH-1:0]        q_index_o,

	// Stream end marker for the result unit
	output      logic                          last_seen_o
);

	logic                   xfer;
	logic [INDEX_WIDTH-1:0] col_cnt;

	// Hold the stream while any single queue is full
	assign act_ready_o = ~(|q_full_i);
	assign xfer        = act_valid_i & act_ready_o;

	// Zeros are accepted but never written
	assign q_we_o    = xfer && (act_i != '0);
	assign q_act_o   = act_i;
	assign q_index_o = col_cnt;

	//////////////////////////////////////////////////////////////////////
	// Column counter and end-of-vector latch
	//////////////////////////////////////////////////////////////////////

	// Every accepted activation takes a column, zero or not
	always_ff @(posedge clk) begin
		if (!rstn || clear_i) begin
			col_cnt <= '0;
		end
		else if (xfer) begin
			col_cnt <= col_cnt + 1'b1;
		end
	end

	// Sticky until the next clear
	always_ff @(posedge clk) begin
		if (!rstn || clear_i) begin
			last_seen_o <= 1'b0;
		end
		else if (xfer && act_last_i) begin
			last_seen_o <= 1'b1;
		end
	end

	// A stalled activation waits unchanged until the queues drain
	a_stall_hold: assert property (@(posedge clk) disable iff (!rstn)
		act_valid_i && !act_ready_o |=> act_valid_i && $stable(act_i) && $stable(act_last_i));

endmodule : ccu_broadcast

`default_nettype wire

// File: hw/pe_queue.sv
// Per-PE activation queue
`timescale 1ns/10ps
`default_nettype none

module pe_queue import act_pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input  wire logic                          clk,
	input  wire logic                          rstn,

	// Write side, driven by the CCU
	input  wire logic signed [ACT_WIDTH-1:0]   act_value_i,
	input  wire logic [INDEX_WIDTH-1:0]        index_i,
	input  wire logic                          we_i,
	output      logic                          full_o,

	// Read side, driven by the PE
	input  wire logic                          re_i,
	output      logic signed [ACT_WIDTH-1:0]   act_value_o,
	output      logic [INDEX_WIDTH-1:0]        index_o,
	output      logic                          empty_o
);

	localparam int PTR_WIDTH = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

	// Pointers plus a round bit that flips on every wrap
	logic [PTR_WIDTH-1:0]    w_ptr;
	logic                    w_round;
	logic [PTR_WIDTH-1:0]    r_ptr;
	logic                    r_round;

	// Storage, {activation, index} per word
	logic [QENTRY_WIDTH-1:0] mem [QUEUE_DEPTH];

	// Same slot, rounds apart by one
	assign full_o  = (w_ptr == r_ptr) && (w_round != r_round);
	// Same slot, same round
	assign empty_o = (w_ptr == r_ptr) && (w_round == r_round);

	//////////////////////////////////////////////////////////////////////
	// Data path
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[w_ptr] <= {act_value_i, index_i};
		end
	end

	// Read word shows up the cycle after re_i
	always_ff @(posedge clk) begin
		if (re_i) begin
			{act_value_o, index_o} <= mem[r_ptr];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Pointers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstn) begin
			w_ptr   <= '0;
			w_round <= 1'b0;
		end
		else if (we_i) begin
			if (w_ptr == PTR_WIDTH'(QUEUE_DEPTH - 1)) begin
				w_ptr   <= '0;
				w_round <= ~w_round;
			end
			else begin
				w_ptr <= w_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			r_ptr   <= '0;
			r_round <= 1'b0;
		end
		else if (re_i) begin
			if (r_ptr == PTR_WIDTH'(QUEUE_DEPTH - 1)) begin
				r_ptr   <= '0;
				r_round <= ~r_round;
			end
			else begin
				r_ptr <= r_ptr + 1'b1;
			end
		end
	end

	// Overflow and underflow guards on the two neighbours
	a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
		we_i |-> !full_o);
	a_no_underflow: assert property (@(posedge clk) disable iff (!rstn)
		re_i |-> !empty_o);

endmodule : pe_queue

`default_nettype wire

// File: hw/pe_mac.sv
// Processing element with row accumulators
`timescale 1ns/10ps
`default_nettype none

module pe_mac import act_pkg::*, pe_pkg::*; #(
	parameter int PE_ID       = 0,
	parameter int ROWS_PER_PE = 2,
	parameter int NUM_COLS    = 16,
	parameter int NUM_PE      = 4,
	localparam int NUM_ROWS   = NUM_PE * ROWS_PER_PE,
	localparam int ROW_WIDTH  = (NUM_ROWS > 1) ? $clog2(NUM_ROWS) : 1,
	localparam int LROW_WIDTH = (ROWS_PER_PE > 1) ? $clog2(ROWS_PER_PE) : 1
) (
	input  wire logic                            clk,
	input  wire logic                            rstn,
	input  wire logic                            clear_i,

	// Weight load, global row numbering
	input  wire logic                            wt_we_i,
	input  wire logic [ROW_WIDTH-1:0]            wt_row_i,
	input  wire logic [INDEX_WIDTH-1:0]          wt_col_i,
	input  wire logic signed [WEIGHT_WIDTH-1:0]  wt_data_i,

	// Own queue
	input  wire logic                            q_empty_i,
	output      logic                            q_re_o,
	input  wire logic signed [ACT_WIDTH-1:0]     q_act_i,
	input  wire logic [INDEX_WIDTH-1:0]          q_index_i,

	// Status and read-out
	output      logic                            busy_o,
	input  wire logic [LROW_WIDTH-1:0]           rd_row_i,
	output      logic signed [ACC_WIDTH-1:0]     rd_acc_o
);

	localparam int ROW_LO     = PE_ID * ROWS_PER_PE;
	localparam int PROD_WIDTH = WEIGHT_WIDTH + ACT_WIDTH;

	logic signed [WEIGHT_WIDTH-1:0] wt_mem [ROWS_PER_PE][NUM_COLS];
	logic signed [ACC_WIDTH-1:0]    acc    [ROWS_PER_PE];
	logic signed [PROD_WIDTH-1:0]   prod   [ROWS_PER_PE];
	logic                           own_row;
	logic [LROW_WIDTH-1:0]          wt_lrow;
	logic                           pop_vld;

	//////////////////////////////////////////////////////////////////////
	// Weight storage
	//////////////////////////////////////////////////////////////////////

	// Only rows ROW_LO .. ROW_LO+ROWS_PER_PE-1 live here
	assign own_row = (int'(wt_row_i) >= ROW_LO) && (int'(wt_row_i) < ROW_LO + ROWS_PER_PE);
	assign wt_lrow = LROW_WIDTH'(int'(wt_row_i) - ROW_LO);

	always_ff @(posedge clk) begin
		if (wt_we_i && own_row) begin
			wt_mem[wt_lrow][wt_col_i] <= wt_data_i;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Queue reader and MAC
	//////////////////////////////////////////////////////////////////////

	// Pop whenever something is waiting
	assign q_re_o = ~q_empty_i;

	// Popped word is on q_act_i/q_index_i one cycle later
	always_ff @(posedge clk) begin
		if (!rstn) begin
			pop_vld <= 1'b0;
		end
		else begin
			pop_vld <= q_re_o;
		end
	end

	assign busy_o = pop_vld;

	// One multiplier per local row, same column
	for (genvar r = 0; r < ROWS_PER_PE; r++) begin : g_row
		assign prod[r] = wt_mem[r][q_index_i] * q_act_i;
	end

	// Sign-extend product, sum wraps at ACC_WIDTH
	always_ff @(posedge clk) begin
		if (!rstn || clear_i) begin
			for (int r = 0; r < ROWS_PER_PE; r++) begin
				acc[r] <= '0;
			end
		end
		else if (pop_vld) begin
			for (int r = 0; r < ROWS_PER_PE; r++) begin
				acc[r] <= acc[r] + {{(ACC_WIDTH-PROD_WIDTH){prod[r][PROD_WIDTH-1]}}, prod[r]};
			end
		end
	end

	// Local row picked by the result unit
	assign rd_acc_o = acc[rd_row_i];

	// Index from the CCU must address a stored column
	a_index_range: assert property (@(posedge clk) disable iff (!rstn)
		pop_vld |-> (int'(q_index_i) < NUM_COLS));

endmodule : pe_mac

`default_nettype wire

// File: hw/result_unit.sv
// Completion and result read-out
`timescale 1ns/10ps
`default_nettype none

module result_unit import pe_pkg::*; #(
	parameter int NUM_PE      = 4,
	parameter int ROWS_PER_PE = 2,
	localparam int NUM_ROWS   = NUM_PE * ROWS_PER_PE,
	localparam int ROW_WIDTH  = (NUM_ROWS > 1) ? $clog2(NUM_ROWS) : 1,
	localparam int LROW_WIDTH = (ROWS_PER_PE > 1) ? $clog2(ROWS_PER_PE) : 1,
	localparam int PE_WIDTH   = (NUM_PE > 1) ? $clog2(NUM_PE) : 1
) (
	input  wire logic                              clk,
	input  wire logic                              rstn,
	input  wire logic                              clear_i,

	// Drain status
	input  wire logic                              last_seen_i,
	input  wire logic [NUM_PE-1:0]                 q_empty_i,
	input  wire logic [NUM_PE-1:0]                 pe_busy_i,
	input  wire logic [NUM_PE-1:0][ACC_WIDTH-1:0]  pe_acc_i,

	// Read request, global row
	input  wire logic                              res_re_i,
	input  wire logic [ROW_WIDTH-1:0]              res_row_i,
	output      logic [LROW_WIDTH-1:0]             rd_row_o,
	output      logic signed [ACC_WIDTH-1:0]       res_o,
	output      logic                              res_valid_o,
	output      logic                              done_o
);

	logic [PE_WIDTH-1:0] pe_sel;

	// Global row -> owning PE and its local row
	assign pe_sel   = PE_WIDTH'(int'(res_row_i) / ROWS_PER_PE);
	assign rd_row_o = LROW_WIDTH'(int'(res_row_i) % ROWS_PER_PE);

	// Stream ended, queues drained, no MAC pending
	always_ff @(posedge clk) begin
		if (!rstn || clear_i) begin
			done_o <= 1'b0;
		end
		else begin
			done_o <= last_seen_i && (&q_empty_i) && !(|pe_busy_i);
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			res_valid_o <= 1'b0;
		end
		else begin
			res_valid_o <= res_re_i;
		end
	end

	// Result word, one cycle behind the request
	always_ff @(posedge clk) begin
		if (res_re_i) begin
			res_o <= pe_acc_i[pe_sel];
		end
	end

endmodule : result_unit

`default_nettype wire

// File: hw/spmv_top.sv
// Sparse matrix-vector accelerator top
`timescale 1ns/10ps
`default_nettype none

module spmv_top import act_pkg::*, pe_pkg::*; #(
	parameter int NUM_PE      = 4,
	parameter int ROWS_PER_PE = 2,
	parameter int NUM_COLS    = 16,
	parameter int QUEUE_DEPTH = 4,
	localparam int NUM_ROWS   = NUM_PE * ROWS_PER_PE,
	localparam int ROW_WIDTH  = (NUM_ROWS > 1) ? $clog2(NUM_ROWS) : 1,
	localparam int LROW_WIDTH = (ROWS_PER_PE > 1) ? $clog2(ROWS_PER_PE) : 1
) (
	input  wire logic                            clk,
	input  wire logic                            rstn,
	input  wire logic                            clear_i,

	// Activation stream
	input  wire logic                            act_valid_i,
	input  wire logic signed [ACT_WIDTH-1:0]     act_i,
	input  wire logic                            act_last_i,
	output      logic                            act_ready_o,

	// Weight load
	input  wire logic                            wt_we_i,
	input  wire logic [ROW_WIDTH-1:0]            wt_row_i,
	input  wire logic [INDEX_WIDTH-1:0]          wt_col_i,
	input  wire logic signed [WEIGHT_WIDTH-1:0]  wt_data_i,

	// Completion and results
	output      logic                            done_o,
	input  wire logic                            res_re_i,
	input  wire logic [ROW_WIDTH-1:0]            res_row_i,
	output      logic signed [ACC_WIDTH-1:0]     res_o,
	output      logic                            res_valid_o
);

	// CCU broadcast bus
	logic                             bc_we;
	logic signed [ACT_WIDTH-1:0]      bc_act;
	logic [INDEX_WIDTH-1:0]           bc_index;
	logic                             last_seen;

	// Per-PE queue and status nets
	logic [NUM_PE-1:0]                q_full;
	logic [NUM_PE-1:0]                q_empty;
	logic [NUM_PE-1:0]                q_re;
	logic signed [ACT_WIDTH-1:0]      q_act   [NUM_PE];
	logic [INDEX_WIDTH-1:0]           q_index [NUM_PE];
	logic [NUM_PE-1:0]                pe_busy;
	logic [NUM_PE-1:0][ACC_WIDTH-1:0] pe_acc;
	logic [LROW_WIDTH-1:0]            rd_row;

	ccu_broadcast #(
		.NUM_PE      (NUM_PE)
	) u_ccu (
		.clk         (clk),
		.rstn        (rstn),
		.clear_i     (clear_i),
		.act_valid_i (act_valid_i),
		.act_i       (act_i),
		.act_last_i  (act_last_i),
		.act_ready_o (act_ready_o),
		.q_full_i    (q_full),
		.q_we_o      (bc_we),
		.q_act_o     (bc_act),
		.q_index_o   (bc_index),
		.last_seen_o (last_seen)
	);

	//////////////////////////////////////////////////////////////////////
	// One queue and one PE per slice of rows
	//////////////////////////////////////////////////////////////////////

	for (genvar p = 0; p < NUM_PE; p++) begin : g_pe
		pe_queue #(
			.QUEUE_DEPTH (QUEUE_DEPTH)
		) u_queue (
			.clk         (clk),
			.rstn        (rstn),
			.act_value_i (bc_act),
			.index_i     (bc_index),
			.we_i        (bc_we),
			.full_o      (q_full[p]),
			.re_i        (q_re[p]),
			.act_value_o (q_act[p]),
			.index_o     (q_index[p]),
			.empty_o     (q_empty[p])
		);

		pe_mac #(
			.PE_ID       (p),
			.ROWS_PER_PE (ROWS_PER_PE),
			.NUM_COLS    (NUM_COLS),
			.NUM_PE      (NUM_PE)
		) u_pe (
			.clk         (clk),
			.rstn        (rstn),
			.clear_i     (clear_i),
			.wt_we_i     (wt_we_i),
			.wt_row_i    (wt_row_i),
			.wt_col_i    (wt_col_i),
			.wt_data_i   (wt_data_i),
			.q_empty_i   (q_empty[p]),
			.q_re_o      (q_re[p]),
			.q_act_i     (q_act[p]),
			.q_index_i   (q_index[p]),
			.busy_o      (pe_busy[p]),
			.rd_row_i    (rd_row),
			.rd_acc_o    (pe_acc[p])
		);
	end

	result_unit #(
		.NUM_PE      (NUM_PE),
		.ROWS_PER_PE (ROWS_PER_PE)
	) u_result (
		.clk         (clk),
		.rstn        (rstn),
		.clear_i     (clear_i),
		.last_seen_i (last_seen),
		.q_empty_i   (q_empty),
		.pe_busy_i   (pe_busy),
		.pe_acc_i    (pe_acc),
		.res_re_i    (res_re_i),
		.res_row_i   (res_row_i),
		.rd_row_o    (rd_row),
		.res_o       (res_o),
		.res_valid_o (res_valid_o),
		.done_o      (done_o)
	);

endmodule : spmv_top

`default_nettype wire

// File: tests/spmv_tb.sv
// Sparse matrix-vector testbench
`timescale 1ns/10ps
`default_nettype none

module spmv_tb;

	localparam int NUM_PE      = 4;
	localparam int ROWS_PER_PE = 2;
	localparam int NUM_COLS    = 16;
	localparam int QUEUE_DEPTH = 4;
	localparam int NUM_ROWS    = NUM_PE * ROWS_PER_PE;
	localparam int WAIT_LIMIT  = 2000;

	logic                clk;
	logic                rstn;
	logic                clear_i;
	logic                act_valid_i;
	logic signed [7:0]   act_i;
	logic                act_last_i;
	logic                act_ready_o;
	logic                wt_we_i;
	logic [2:0]          wt_row_i;
	logic [3:0]          wt_col_i;
	logic signed [7:0]   wt_data_i;
	logic                done_o;
	logic                res_re_i;
	logic [2:0]          res_row_i;
	logic signed [23:0]  res_o;
	logic                res_valid_o;

	// Reference weights and activation stream
	int     wt [NUM_ROWS][NUM_COLS];
	int     stream [$];
	int     errors;
	int     checks;
	int     tests;
	int     test_start_err;
	integer seed;

	spmv_top #(
		.NUM_PE      (NUM_PE),
		.ROWS_PER_PE (ROWS_PER_PE),
		.NUM_COLS    (NUM_COLS),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) UUT (
		.clk         (clk),
		.rstn        (rstn),
		.clear_i     (clear_i),
		.act_valid_i (act_valid_i),
		.act_i       (act_i),
		.act_last_i  (act_last_i),
		.act_ready_o (act_ready_o),
		.wt_we_i     (wt_we_i),
		.wt_row_i    (wt_row_i),
		.wt_col_i    (wt_col_i),
		.wt_data_i   (wt_data_i),
		.done_o      (done_o),
		.res_re_i    (res_re_i),
		.res_row_i   (res_row_i),
		.res_o       (res_o),
		.res_valid_o (res_valid_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Row dot product, column is transfer count mod 16, 24-bit wrap
	function automatic logic signed [23:0] expected_row(input int r);
		logic signed [23:0] sum;
		sum = '0;
		for (int i = 0; i < stream.size(); i++) begin
			sum = sum + 24'(wt[r][i % NUM_COLS] * stream[i]);
		end
		return sum;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Bus tasks, entered and left just after a rising edge
	//////////////////////////////////////////////////////////////////////

	task automatic load_weights();
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int c = 0; c < NUM_COLS; c++) begin
				wt_we_i   <= 1'b1;
				wt_row_i  <= 3'(r);
				wt_col_i  <= 4'(c);
				wt_data_i <= 8'(wt[r][c]);
				@(posedge clk);
			end
		end
		wt_we_i <= 1'b0;
	endtask

	task automatic pulse_clear();
		clear_i <= 1'b1;
		@(posedge clk);
		clear_i <= 1'b0;
	endtask

	// Valid stays high from first to last item
	task automatic stream_vector();
		int   waited;
		logic rdy;
		for (int i = 0; i < stream.size(); i++) begin
			act_valid_i <= 1'b1;
			act_i       <= 8'(stream[i]);
			act_last_i  <= (i == stream.size() - 1);
			waited = 0;
			rdy    = 1'b0;
			// Hold the item until an edge with ready high
			while (!rdy && waited < WAIT_LIMIT) begin
				@(negedge clk);
				rdy = act_ready_o;
				@(posedge clk);
				waited++;
			end
			assert (rdy) else begin
				$display("Timeout: act_ready_o stayed low at item %0d", i);
				errors++;
			end
		end
		act_valid_i <= 1'b0;
		act_last_i  <= 1'b0;
	endtask

	task automatic wait_done();
		int   waited;
		logic seen;
		waited = 0;
		seen   = 1'b0;
		while (!seen && waited < WAIT_LIMIT) begin
			@(negedge clk);
			seen = done_o;
			waited++;
		end
		@(posedge clk);
		assert (seen) else begin
			$display("Timeout: done_o never rose after the last activation");
			errors++;
		end
	endtask

	task automatic read_rows();
		logic signed [23:0] exp_val;
		for (int r = 0; r < NUM_ROWS; r++) begin
			exp_val = expected_row(r);
			res_re_i  <= 1'b1;
			res_row_i <= 3'(r);
			@(posedge clk);
			res_re_i <= 1'b0;
			// Result registered on that edge
			@(negedge clk);
			checks += 2;
			assert (res_valid_o) else begin
				$display("Mismatch at %0t: res_valid_o expected 1, got %0b", $time, res_valid_o);
				errors++;
			end
			assert (res_o == exp_val) else begin
				$display("Mismatch at %0t: res_o row %0d expected %0d, got %0d",
					$time, r, exp_val, res_o);
				errors++;
			end
			@(posedge clk);
		end
	endtask

	task automatic run_vector();
		pulse_clear();
		stream_vector();
		wait_done();
		read_rows();
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("Test %0d %s: %s, %0d errors", tests, name,
			(errors == test_start_err) ? "passed" : "failed", errors - test_start_err);
		test_start_err = errors;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_dense();
		@(negedge clk);
		checks += 2;
		assert (act_ready_o) else begin
			$display("Mismatch at %0t: act_ready_o expected 1, got %0b", $time, act_ready_o);
			errors++;
		end
		assert (!done_o) else begin
			$display("Mismatch at %0t: done_o expected 0, got %0b", $time, done_o);
			errors++;
		end
		@(posedge clk);
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int c = 0; c < NUM_COLS; c++) begin
				wt[r][c] = (r * 7 + c * 3) % 41 - 20;
			end
		end
		stream.delete();
		// Every entry nonzero, signs alternate
		for (int c = 0; c < NUM_COLS; c++) begin
			stream.push_back((c % 2) ? -(c + 1) : (c + 1) * 3);
		end
		load_weights();
		run_vector();
		finish_test("dense vector");
	endtask

	task automatic test_sparse();
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int c = 0; c < NUM_COLS; c++) begin
				wt[r][c] = ((r + 1) * (c + 2)) % 31 - 15;
			end
		end
		stream.delete();
		for (int c = 0; c < NUM_COLS; c++) begin
			stream.push_back(0);
		end
		// Leading zeros push the first index to 2
		stream[2]  = 9;
		stream[7]  = -50;
		stream[13] = 77;
		stream[15] = -3;
		load_weights();
		run_vector();
		finish_test("sparse vector");
	endtask

	task automatic test_all_zero();
		stream.delete();
		for (int c = 0; c < NUM_COLS; c++) begin
			stream.push_back(0);
		end
		run_vector();
		finish_test("all-zero vector");
	endtask

	task automatic test_wrap_stream();
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int c = 0; c < NUM_COLS; c++) begin
				wt[r][c] = (r % 2) ? 127 : -128;
			end
		end
		stream.delete();
		// 34 passes over the columns, sums run past 2**23
		for (int i = 0; i < 34 * NUM_COLS; i++) begin
			stream.push_back(-128);
		end
		load_weights();
		run_vector();
		finish_test("continuous stream with wrap");
	endtask

	task automatic test_clear_between();
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int c = 0; c < NUM_COLS; c++) begin
				wt[r][c] = 100 - r * 13 - c;
			end
		end
		stream.delete();
		for (int c = 0; c < NUM_COLS; c++) begin
			stream.push_back(120 - c * 9);
		end
		load_weights();
		run_vector();
		// Second vector, new weights, old sums must be gone
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int c = 0; c < NUM_COLS; c++) begin
				wt[r][c] = (c * 11 + r * 5) % 17 - 8;
			end
		end
		stream.delete();
		for (int c = 0; c < NUM_COLS; c++) begin
			stream.push_back((c % 3 == 0) ? 0 : c * 4 - 30);
		end
		load_weights();
		run_vector();
		finish_test("clear between vectors");
	endtask

	task automatic test_random();
		int v;
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int c = 0; c < NUM_COLS; c++) begin
				wt[r][c] = $random(seed) % 128;
			end
		end
		stream.delete();
		// About a quarter forced to zero
		for (int c = 0; c < NUM_COLS; c++) begin
			v = $random(seed) % 128;
			if (($random(seed) & 3) == 0) begin
				v = 0;
			end
			stream.push_back(v);
		end
		load_weights();
		run_vector();
		finish_test("seeded random matrix");
	endtask

	initial begin
		seed           = 32'h6565_fe3a;
		errors         = 0;
		checks         = 0;
		tests          = 0;
		test_start_err = 0;
		rstn           = 1'b0;
		clear_i        = 1'b0;
		act_valid_i    = 1'b0;
		act_i          = '0;
		act_last_i     = 1'b0;
		wt_we_i        = 1'b0;
		wt_row_i       = '0;
		wt_col_i       = '0;
		wt_data_i      = '0;
		res_re_i       = 1'b0;
		res_row_i      = '0;
		repeat (5) @(posedge clk);
		rstn <= 1'b1;
		@(posedge clk);
		test_dense();
		test_sparse();
		test_all_zero();
		test_wrap_stream();
		test_clear_between();
		test_random();
		$display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end
		else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule : spmv_tb

`default_nettype wire

// File: filelist.f
hw/act_pkg.sv
hw/pe_pkg.sv
hw/ccu_broadcast.sv
hw/pe_queue.sv
hw/pe_mac.sv
hw/result_unit.sv
hw/spmv_top.sv
tests/spmv_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the spmv testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module spmv_tb -o spmv_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/spmv_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
	echo "No pass message found in $LOG"
	exit 1
fi
exit 0
